// ==== ipu_pkg.sv ====
/* Shared definitions of the integer processing unit: data widths,
   instruction fields, opcodes, ALU and operand enums, request, response
   and decode structs */

package ipu_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 5;
  localparam int unsigned NumRegs   = 32;

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [31:0]          instr_t;
  typedef logic [4:0]           reg_addr_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [4:0]           shamt_t;
  typedef logic [6:0]           opcode_t;

  // Instruction fields
  localparam int unsigned OpcodeLsb = 0;
  localparam int unsigned OpcodeMsb = 6;
  localparam int unsigned RdLsb     = 7;
  localparam int unsigned RdMsb     = 11;
  localparam int unsigned Rs1Lsb    = 15;
  localparam int unsigned Rs1Msb    = 19;
  localparam int unsigned Rs2Lsb    = 20;
  localparam int unsigned Rs2Msb    = 24;
  localparam int unsigned ImmLsb    = 20;
  localparam int unsigned ImmMsb    = 31;

  // ----------------------------------------
  // Opcodes, all others are illegal
  // ----------------------------------------
  localparam opcode_t ANDN    = 7'h01;
  localparam opcode_t ORN     = 7'h02;
  localparam opcode_t XNOR    = 7'h03;
  localparam opcode_t MIN     = 7'h04;
  localparam opcode_t MAX     = 7'h05;
  localparam opcode_t MINU    = 7'h06;
  localparam opcode_t MAXU    = 7'h07;
  localparam opcode_t CLZ     = 7'h08;
  localparam opcode_t PCNT    = 7'h09;
  localparam opcode_t IMV_X_W = 7'h10;
  localparam opcode_t IMV_W_X = 7'h11;
  localparam opcode_t IADDI   = 7'h20;
  localparam opcode_t IXORI   = 7'h21;
  localparam opcode_t ISLLI   = 7'h22;
  localparam opcode_t ISRAI   = 7'h23;
  localparam opcode_t IADD    = 7'h30;
  localparam opcode_t ISUB    = 7'h31;
  localparam opcode_t ISLT    = 7'h32;
  localparam opcode_t ISLTU   = 7'h33;
  localparam opcode_t IAND    = 7'h34;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRA,
    ALU_ANDN, ALU_ORN, ALU_XNOR,
    ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU,
    ALU_CLZ, ALU_PCNT
  } alu_op_e;

  typedef enum logic [1:0] {
    OpNone,
    OpAccBus,
    OpIImm,
    OpReg
  } op_sel_e;

  typedef struct packed {
    instr_t instr;
    id_t    id;
    word_t  arga;
    word_t  argb;
  } ipu_req_t;

  typedef struct packed {
    word_t data;
    logic  error;
    id_t   id;
  } ipu_resp_t;

  typedef struct packed {
    alu_op_e alu_op;
    op_sel_e op_a_sel;
    op_sel_e op_b_sel;
    logic    write_rf;
    logic    send_resp;
    logic    illegal;
  } ipu_dec_t;

endpackage

// ==== ipu_req_queue.sv ====
/* Request FIFO between the accelerator port and the issue stage,
   circular buffer with fill count and same-cycle push and pop */

`timescale 1ns/1ns

module ipu_req_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  ipu_pkg::ipu_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output ipu_pkg::ipu_req_t  head_o,
  output logic               head_valid_o,
  input  logic               pop_i
);

  import ipu_pkg::*;

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  ipu_req_t             mem_q [QueueDepth];
  logic [PtrWidth-1:0]  rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 push;

  assign req_ready_o  = (count_q != CntWidth'(QueueDepth));
  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign push         = req_valid_i & req_ready_o;

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Both at once leaves the fill level unchanged
      if (push && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Issue stage must only pop a valid head
  assert property (@(posedge clk_i) disable iff (!arst_n_i) pop_i |-> head_valid_o)
    else $error("pop on empty request queue");

endmodule

// ==== ipu_decoder.sv ====
/* Instruction decoder, opcode to ALU operator, operand sources
   and destination */

`timescale 1ns/1ns

module ipu_decoder (
  input  ipu_pkg::instr_t  instr_i,
  output ipu_pkg::ipu_dec_t dec_o
);

  import ipu_pkg::*;

  opcode_t opcode;
  alu_op_e alu_op;

  assign opcode = instr_i[OpcodeMsb:OpcodeLsb];

  // Operator per opcode, moves pass operand a through an OR with zero
  always_comb begin
    case (opcode)
      ANDN:    alu_op = ALU_ANDN;
      ORN:     alu_op = ALU_ORN;
      XNOR:    alu_op = ALU_XNOR;
      MIN:     alu_op = ALU_MIN;
      MAX:     alu_op = ALU_MAX;
      MINU:    alu_op = ALU_MINU;
      MAXU:    alu_op = ALU_MAXU;
      CLZ:     alu_op = ALU_CLZ;
      PCNT:    alu_op = ALU_PCNT;
      IADDI:   alu_op = ALU_ADD;
      IXORI:   alu_op = ALU_XOR;
      ISLLI:   alu_op = ALU_SLL;
      ISRAI:   alu_op = ALU_SRA;
      IADD:    alu_op = ALU_ADD;
      ISUB:    alu_op = ALU_SUB;
      ISLT:    alu_op = ALU_SLT;
      ISLTU:   alu_op = ALU_SLTU;
      IAND:    alu_op = ALU_AND;
      default: alu_op = ALU_OR;
    endcase
  end

  // ----------------------------------------
  // Operand sources and destination
  // ----------------------------------------
  always_comb begin
    dec_o.alu_op    = alu_op;
    dec_o.op_a_sel  = OpNone;
    dec_o.op_b_sel  = OpNone;
    dec_o.write_rf  = 1'b0;
    dec_o.send_resp = 1'b0;
    dec_o.illegal   = 1'b0;

    unique case (opcode)
      ANDN, ORN, XNOR, MIN, MAX, MINU, MAXU, CLZ, PCNT: begin
        dec_o.op_a_sel  = OpAccBus;
        dec_o.op_b_sel  = OpAccBus;
        dec_o.send_resp = 1'b1;
      end
      IADDI, IXORI, ISLLI, ISRAI: begin
        dec_o.op_a_sel = OpReg;
        dec_o.op_b_sel = OpIImm;
        dec_o.write_rf = 1'b1;
      end
      IADD, ISUB, ISLT, ISLTU, IAND: begin
        dec_o.op_a_sel = OpReg;
        dec_o.op_b_sel = OpReg;
        dec_o.write_rf = 1'b1;
      end
      // Register file back to the core
      IMV_X_W: begin
        dec_o.op_a_sel  = OpReg;
        dec_o.send_resp = 1'b1;
      end
      // Core into the register file
      IMV_W_X: begin
        dec_o.op_a_sel = OpAccBus;
        dec_o.write_rf = 1'b1;
      end
      default: begin
        dec_o.illegal   = 1'b1;
        dec_o.send_resp = 1'b1;
      end
    endcase
  end

endmodule

// ==== ipu_alu.sv ====
/* Single-cycle integer ALU: arithmetic, compare, shifts, logic,
   min/max, leading-zero count and population count */

`timescale 1ns/1ns

module ipu_alu (
  input  ipu_pkg::alu_op_e op_i,
  input  ipu_pkg::word_t   operand_a_i,
  input  ipu_pkg::word_t   operand_b_i,
  output ipu_pkg::word_t   result_o
);

  import ipu_pkg::*;

  // Zero input gives the full width
  function automatic word_t count_lz(word_t value);
    word_t cnt;
    cnt = word_t'(DataWidth);
    for (int i = 0; i < DataWidth; i++) begin
      if (value[i]) begin
        cnt = word_t'(DataWidth - 1 - i);
      end
    end
    return cnt;
  endfunction

  function automatic word_t count_ones(word_t value);
    word_t cnt;
    cnt = '0;
    for (int i = 0; i < DataWidth; i++) begin
      cnt = cnt + word_t'(value[i]);
    end
    return cnt;
  endfunction

  shamt_t shamt;
  logic   lt_signed;
  logic   lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  // ----------------------------------------
  // Result mux
  // ----------------------------------------
  always_comb begin
    result_o = '0;
    unique case (op_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_SLT:  result_o = word_t'(lt_signed);
      ALU_SLTU: result_o = word_t'(lt_unsigned);
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRA:  result_o = word_t'($signed(operand_a_i) >>> shamt);
      ALU_ANDN: result_o = operand_a_i & ~operand_b_i;
      ALU_ORN:  result_o = operand_a_i | ~operand_b_i;
      ALU_XNOR: result_o = ~(operand_a_i ^ operand_b_i);
      // Min and max reuse the compare results
      ALU_MIN:  result_o = lt_signed ? operand_a_i : operand_b_i;
      ALU_MAX:  result_o = lt_signed ? operand_b_i : operand_a_i;
      ALU_MINU: result_o = lt_unsigned ? operand_a_i : operand_b_i;
      ALU_MAXU: result_o = lt_unsigned ? operand_b_i : operand_a_i;
      ALU_CLZ:  result_o = count_lz(operand_a_i);
      ALU_PCNT: result_o = count_ones(operand_a_i);
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== ipu_regfile.sv ====
/* 32 x 32 integer register file, two combinational read ports,
   one write port */

`timescale 1ns/1ns

module ipu_regfile (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  ipu_pkg::reg_addr_t raddr_a_i,
  input  ipu_pkg::reg_addr_t raddr_b_i,
  output ipu_pkg::word_t     rdata_a_o,
  output ipu_pkg::word_t     rdata_b_o,
  input  logic               we_i,
  input  ipu_pkg::reg_addr_t waddr_i,
  input  ipu_pkg::word_t     wdata_i
);

  import ipu_pkg::*;

  word_t regs_q [NumRegs];

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // x0 is writable like every other entry
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

// ==== ipu_issue.sv ====
/* Issue stage: operand selection, retire and stall control,
   register write-back and response forming */

`timescale 1ns/1ns

module ipu_issue (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  ipu_pkg::ipu_req_t   head_i,
  input  logic                head_valid_i,
  output logic                pop_o,
  input  ipu_pkg::ipu_dec_t   dec_i,
  output ipu_pkg::reg_addr_t  rs1_o,
  output ipu_pkg::reg_addr_t  rs2_o,
  input  ipu_pkg::word_t      rdata_a_i,
  input  ipu_pkg::word_t      rdata_b_i,
  output ipu_pkg::alu_op_e    alu_op_o,
  output ipu_pkg::word_t      alu_a_o,
  output ipu_pkg::word_t      alu_b_o,
  input  ipu_pkg::word_t      alu_result_i,
  output logic                we_o,
  output ipu_pkg::reg_addr_t  waddr_o,
  output ipu_pkg::word_t      wdata_o,
  output ipu_pkg::ipu_resp_t  resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i
);

  import ipu_pkg::*;

  function automatic word_t select_operand(op_sel_e sel, word_t reg_val, word_t acc_val,
                                           word_t imm_val);
    word_t operand;
    operand = '0;
    unique case (sel)
      OpReg:    operand = reg_val;
      OpAccBus: operand = acc_val;
      OpIImm:   operand = imm_val;
      default:  operand = '0;
    endcase
    return operand;
  endfunction

  word_t iimm;
  logic  stall;
  logic  retire;

  assign iimm  = word_t'($signed(head_i.instr[ImmMsb:ImmLsb]));
  assign rs1_o = head_i.instr[Rs1Msb:Rs1Lsb];
  assign rs2_o = head_i.instr[Rs2Msb:Rs2Lsb];

  assign alu_op_o = dec_i.alu_op;
  assign alu_a_o  = select_operand(dec_i.op_a_sel, rdata_a_i, head_i.arga, iimm);
  assign alu_b_o  = select_operand(dec_i.op_b_sel, rdata_b_i, head_i.argb, iimm);

  // ----------------------------------------
  // Retire and write-back
  // ----------------------------------------
  assign stall   = resp_valid_o & ~resp_ready_i;
  assign retire  = head_valid_i & ~stall;
  assign pop_o   = retire;
  assign we_o    = retire & dec_i.write_rf;
  assign waddr_o = head_i.instr[RdMsb:RdLsb];
  assign wdata_o = alu_result_i;

  // Illegal instructions answer with zero data
  assign resp_valid_o = head_valid_i & dec_i.send_resp;
  assign resp_o.data  = dec_i.illegal ? '0 : alu_result_i;
  assign resp_o.error = dec_i.illegal;
  assign resp_o.id    = head_i.id;

  // Head and register file must hold while the core back-pressures
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall |=> resp_valid_o && $stable(resp_o))
    else $error("response changed while stalled");

endmodule

// ==== ipu_int_ss.sv ====
/* Integer processing unit top: request queue, decoder, issue stage,
   ALU and register file */

`timescale 1ns/1ns

module ipu_int_ss #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  ipu_pkg::ipu_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output ipu_pkg::ipu_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  import ipu_pkg::*;

  ipu_req_t  head;
  logic      head_valid;
  logic      head_pop;
  ipu_dec_t  dec;
  reg_addr_t rs1, rs2, waddr;
  word_t     rdata_a, rdata_b, wdata;
  word_t     alu_a, alu_b, alu_result;
  alu_op_e   alu_op;
  logic      we;

  ipu_req_queue #(
    .QueueDepth ( QueueDepth )
  ) i_req_queue (
    .clk_i,
    .arst_n_i,
    .req_i        ( acc_req_i       ),
    .req_valid_i  ( acc_req_valid_i ),
    .req_ready_o  ( acc_req_ready_o ),
    .head_o       ( head            ),
    .head_valid_o ( head_valid      ),
    .pop_i        ( head_pop        )
  );

  ipu_decoder i_decoder (
    .instr_i ( head.instr ),
    .dec_o   ( dec        )
  );

  ipu_issue i_issue (
    .clk_i,
    .arst_n_i,
    .head_i       ( head             ),
    .head_valid_i ( head_valid       ),
    .pop_o        ( head_pop         ),
    .dec_i        ( dec              ),
    .rs1_o        ( rs1              ),
    .rs2_o        ( rs2              ),
    .rdata_a_i    ( rdata_a          ),
    .rdata_b_i    ( rdata_b          ),
    .alu_op_o     ( alu_op           ),
    .alu_a_o      ( alu_a            ),
    .alu_b_o      ( alu_b            ),
    .alu_result_i ( alu_result       ),
    .we_o         ( we               ),
    .waddr_o      ( waddr            ),
    .wdata_o      ( wdata            ),
    .resp_o       ( acc_resp_o       ),
    .resp_valid_o ( acc_resp_valid_o ),
    .resp_ready_i ( acc_resp_ready_i )
  );

  ipu_alu i_alu (
    .op_i        ( alu_op     ),
    .operand_a_i ( alu_a      ),
    .operand_b_i ( alu_b      ),
    .result_o    ( alu_result )
  );

  ipu_regfile i_regfile (
    .clk_i,
    .arst_n_i,
    .raddr_a_i ( rs1     ),
    .raddr_b_i ( rs2     ),
    .rdata_a_o ( rdata_a ),
    .rdata_b_o ( rdata_b ),
    .we_i      ( we      ),
    .waddr_i   ( waddr   ),
    .wdata_i   ( wdata   )
  );

endmodule

// ==== tb_ipu_tests.svh ====
/* Directed tests: move round trip, bitmanip, register arithmetic chain,
   illegal opcode, back-pressure ordering and reset state */

`ifndef TB_IPU_TESTS_SVH
`define TB_IPU_TESTS_SVH

// Register file back to the core, compared with the model
task automatic read_back_reg(input reg_addr_t rs);
  id_t id;
  send_req(encode_reg_instr(IMV_X_W, '0, rs, '0), '0, '0, id);
  expect_resp($sformatf("acc_resp_o x%0d", rs), model[rs], 1'b0, id);
endtask

task automatic imm_step(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs1,
                        input logic [11:0] imm);
  id_t id;
  send_req(encode_imm_instr(op, rd, rs1, imm), '0, '0, id);
  model[rd] = ref_result(op, model[rs1], sext_imm(imm));
endtask

task automatic reg_step(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs1,
                        input reg_addr_t rs2);
  id_t id;
  send_req(encode_reg_instr(op, rd, rs1, rs2), '0, '0, id);
  model[rd] = ref_result(op, model[rs1], model[rs2]);
endtask

task automatic move_round_trip();
  reg_addr_t rd;
  word_t     val;
  id_t       id;
  start_test("move round trip");
  for (int k = 0; k < NumMoveRegs; k++) begin
    rd  = reg_addr_t'(1 + 5 * k);
    val = $urandom;
    send_req(encode_reg_instr(IMV_W_X, rd, '0, '0), val, '0, id);
    model[rd] = val;
  end
  for (int k = 0; k < NumMoveRegs; k++) begin
    read_back_reg(reg_addr_t'(1 + 5 * k));
  end
  finish_test();
endtask

task automatic bitmanip_ops();
  opcode_t ops [9];
  word_t   pa [NumPairs];
  word_t   pb [NumPairs];
  id_t     id;
  start_test("bitmanip");
  ops = '{ANDN, ORN, XNOR, MIN, MAX, MINU, MAXU, CLZ, PCNT};
  // Edge pairs first, the rest random
  pa  = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h0, 32'h0};
  pb  = '{32'hffff_ffff, 32'h0, 32'h7fff_ffff, 32'h0000_0001, 32'h0, 32'h0};
  for (int p = 4; p < NumPairs; p++) begin
    pa[p] = $urandom;
    pb[p] = $urandom;
  end
  foreach (ops[i]) begin
    for (int p = 0; p < NumPairs; p++) begin
      send_req(encode_reg_instr(ops[i], '0, '0, '0), pa[p], pb[p], id);
      expect_resp($sformatf("acc_resp_o op %h pair %0d", ops[i], p),
                  ref_result(ops[i], pa[p], pb[p]), 1'b0, id);
    end
  end
  finish_test();
endtask

task automatic reg_arith_chain();
  id_t id;
  start_test("register arithmetic");
  model[10] = $urandom;
  model[11] = $urandom;
  send_req(encode_reg_instr(IMV_W_X, 5'd10, '0, '0), model[10], '0, id);
  send_req(encode_reg_instr(IMV_W_X, 5'd11, '0, '0), model[11], '0, id);
  // Each step reads what the one before wrote
  imm_step(IADDI, 5'd12, 5'd10, 12'hffb);
  imm_step(IXORI, 5'd13, 5'd12, 12'h5a5);
  imm_step(ISLLI, 5'd14, 5'd13, 12'd7);
  imm_step(ISRAI, 5'd15, 5'd14, 12'd3);
  reg_step(IADD,  5'd16, 5'd15, 5'd11);
  reg_step(ISUB,  5'd17, 5'd16, 5'd10);
  reg_step(ISLT,  5'd18, 5'd17, 5'd11);
  reg_step(ISLTU, 5'd19, 5'd17, 5'd11);
  reg_step(IAND,  5'd20, 5'd16, 5'd17);
  for (int r = 12; r <= 20; r++) begin
    read_back_reg(reg_addr_t'(r));
  end
  finish_test();
endtask

task automatic illegal_opcode();
  opcode_t bad [2];
  id_t     id;
  start_test("illegal opcode");
  bad = '{7'h00, 7'h7f};
  foreach (bad[i]) begin
    send_req(encode_reg_instr(bad[i], 5'd3, 5'd1, 5'd2), $urandom, $urandom, id);
    expect_resp($sformatf("acc_resp_o opcode %h", bad[i]), '0, 1'b1, id);
  end
  // No write-back from an illegal instruction
  read_back_reg(5'd3);
  finish_test();
endtask

task automatic backpressure_order();
  id_t ids [QueueDepth + 1];
  start_test("back-pressure");
  @(posedge clk);
  #DriveDelay;
  resp_ready = 1'b0;
  for (int k = 0; k < QueueDepth; k++) begin
    send_req(encode_reg_instr(IMV_X_W, '0, reg_addr_t'(12 + k), '0), '0, '0, ids[k]);
  end
  @(negedge clk);
  check_bit("acc_req_ready_o", req_ready, 1'b0);
  check_bit("acc_resp_valid_o", resp_valid, 1'b1);
  ids[QueueDepth] = next_id;
  next_id++;
  drive_req(encode_reg_instr(IMV_X_W, '0, reg_addr_t'(12 + QueueDepth), '0), '0, '0,
            ids[QueueDepth]);
  repeat (3) begin
    @(negedge clk);
    check_bit("acc_req_ready_o", req_ready, 1'b0);
    // Stalled head keeps offering the first read
    check_word("acc_resp_o.data", resp.data, model[12]);
  end
  @(posedge clk);
  #DriveDelay;
  resp_ready = 1'b1;
  wait_accept();
  for (int k = 0; k <= QueueDepth; k++) begin
    expect_resp($sformatf("acc_resp_o entry %0d", k), model[12 + k], 1'b0, ids[k]);
  end
  finish_test();
endtask

task automatic reset_state();
  id_t id;
  start_test("reset state");
  // Nonzero word in x5 for the reset to clear
  model[5] = $urandom | 32'h1;
  send_req(encode_reg_instr(IMV_W_X, 5'd5, '0, '0), model[5], '0, id);
  read_back_reg(5'd5);
  @(posedge clk);
  #DriveDelay;
  apply_reset();
  @(negedge clk);
  check_bit("acc_resp_valid_o", resp_valid, 1'b0);
  check_bit("acc_req_ready_o", req_ready, 1'b1);
  read_back_reg(5'd5);
  finish_test();
endtask

`endif

// ==== tb_ipu_int_ss.sv ====
/* Testbench top for the integer processing unit: clock, reset, DUT,
   request driver, response monitor, compare tasks, timeout and summary */

`timescale 1ns/1ns

module tb_ipu_int_ss;

  import ipu_pkg::*;

  localparam int unsigned QueueDepth  = 4;
  localparam int unsigned NumMoveRegs = 6;
  localparam int unsigned NumPairs    = 6;
  localparam int unsigned DriveDelay  = 1;
  // Requests per test: moves, bitmanip, arithmetic chain, illegal, back-pressure, reset
  localparam int unsigned NumRequests = 2 * NumMoveRegs + 9 * NumPairs + 20 + 3
                                        + QueueDepth + 1 + 3;
  localparam int unsigned MaxCycles   = 12 * NumRequests + 100;

  logic        clk = 1'b0;
  logic        arst_n;
  ipu_req_t    req;
  logic        req_valid;
  logic        req_ready;
  ipu_resp_t   resp;
  logic        resp_valid;
  logic        resp_ready;

  word_t       model [NumRegs];
  ipu_resp_t   resp_q [$];
  id_t         next_id = '0;
  int unsigned cycle_cnt = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned test_err_start = 0;
  string       test_name;

  always #5 clk = ~clk;

  ipu_int_ss #(
    .QueueDepth ( QueueDepth )
  ) i_dut (
    .clk_i            ( clk        ),
    .arst_n_i         ( arst_n     ),
    .acc_req_i        ( req        ),
    .acc_req_valid_i  ( req_valid  ),
    .acc_req_ready_o  ( req_ready  ),
    .acc_resp_o       ( resp       ),
    .acc_resp_valid_o ( resp_valid ),
    .acc_resp_ready_i ( resp_ready )
  );

  // Collect responses mid-cycle, the transfer happens at the next rising edge
  always @(negedge clk) begin
    if (arst_n && resp_valid && resp_ready) begin
      resp_q.push_back(resp);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Encoding and reference model
  // ----------------------------------------
  function automatic instr_t encode_reg_instr(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                              reg_addr_t rs2);
    instr_t instr;
    instr = '0;
    instr[OpcodeMsb:OpcodeLsb] = op;
    instr[RdMsb:RdLsb]         = rd;
    instr[Rs1Msb:Rs1Lsb]       = rs1;
    instr[Rs2Msb:Rs2Lsb]       = rs2;
    return instr;
  endfunction

  function automatic instr_t encode_imm_instr(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                              logic [11:0] imm);
    instr_t instr;
    instr = '0;
    instr[OpcodeMsb:OpcodeLsb] = op;
    instr[RdMsb:RdLsb]         = rd;
    instr[Rs1Msb:Rs1Lsb]       = rs1;
    instr[ImmMsb:ImmLsb]       = imm;
    return instr;
  endfunction

  function automatic word_t sext_imm(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t ref_result(opcode_t op, word_t a, word_t b);
    word_t res;
    int    n;
    res = '0;
    n   = 0;
    case (op)
      ANDN:         res = a & ~b;
      ORN:          res = a | ~b;
      XNOR:         res = a ~^ b;
      MIN:          res = ($signed(a) <= $signed(b)) ? a : b;
      MAX:          res = ($signed(a) >= $signed(b)) ? a : b;
      MINU:         res = (a <= b) ? a : b;
      MAXU:         res = (a >= b) ? a : b;
      CLZ: begin
        while (n < 32 && !a[31 - n]) begin
          n++;
        end
        res = word_t'(n);
      end
      PCNT:         res = word_t'($countones(a));
      IADDI, IADD:  res = a + b;
      IXORI:        res = a ^ b;
      ISLLI:        res = a << b[4:0];
      ISRAI:        res = word_t'($signed(a) >>> b[4:0]);
      ISUB:         res = a - b;
      ISLT:         res = {31'b0, ($signed(a) < $signed(b))};
      ISLTU:        res = {31'b0, (a < b)};
      IAND:         res = a & b;
      default:      res = '0;
    endcase
    return res;
  endfunction

  // ----------------------------------------
  // Reset, driver and monitor
  // ----------------------------------------
  task automatic apply_reset();
    arst_n     = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    repeat (2) @(posedge clk);
    #DriveDelay;
    arst_n = 1'b1;
    resp_q.delete();
    for (int r = 0; r < NumRegs; r++) begin
      model[r] = '0;
    end
  endtask

  task automatic drive_req(input instr_t instr, input word_t a, input word_t b, input id_t id);
    @(posedge clk);
    #DriveDelay;
    req.instr = instr;
    req.id    = id;
    req.arga  = a;
    req.argb  = b;
    req_valid = 1'b1;
  endtask

  task automatic wait_accept();
    do begin
      @(negedge clk);
    end while (!req_ready);
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;
  endtask

  task automatic send_req(input instr_t instr, input word_t a, input word_t b,
                          output id_t id);
    id = next_id;
    next_id++;
    drive_req(instr, a, b, id);
    wait_accept();
  endtask

  task automatic get_resp(output ipu_resp_t r);
    while (resp_q.size() == 0) begin
      @(posedge clk);
    end
    r = resp_q.pop_front();
  endtask

  // ----------------------------------------
  // Compare tasks and bookkeeping
  // ----------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_resp(input string name, input ipu_resp_t got, input ipu_resp_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s: got data %h error %h id %h, expected data %h error %h id %h",
               name, got.data, got.error, got.id, want.data, want.error, want.id);
    end
  endtask

  task automatic expect_resp(input string name, input word_t data, input logic error,
                             input id_t id);
    ipu_resp_t got;
    ipu_resp_t want;
    get_resp(got);
    want.data  = data;
    want.error = error;
    want.id    = id;
    check_resp(name, got, want);
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == test_err_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_err_start);
    end
  endtask

  `include "tb_ipu_tests.svh"

  initial begin
    void'($urandom(32'h42bb_4ab6));
    apply_reset();
    move_round_trip();
    bitmanip_ops();
    reg_arith_chain();
    illegal_opcode();
    backpressure_order();
    reset_state();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
ipu_pkg.sv
ipu_req_queue.sv
ipu_decoder.sv
ipu_alu.sv
ipu_regfile.sv
ipu_issue.sv
ipu_int_ss.sv
tb_ipu_int_ss.sv

// ==== Makefile ====
# Verilator build and run for the integer processing unit testbench

TOP = tb_ipu_int_ss

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module $(TOP) -f list.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
